// ==== design/icache_bypass_config.svh ====
// ************************************************
// Instruction fetch bypass configuration
// Port count, widths and refill FIFO depth
// ************************************************

`ifndef ICACHE_BYPASS_CONFIG_SVH
`define ICACHE_BYPASS_CONFIG_SVH

// Number of fetch ports sharing the refill port
`define ICB_NR_FETCH_PORTS 2

// Fetch address and instruction word widths
`define ICB_FETCH_AW 32
`define ICB_FETCH_DW 32

// One refill returns a whole cache line
`define ICB_LINE_WIDTH 128

// Refills that may be outstanding at once
`define ICB_RSP_FIFO_DEPTH 4

`endif

// ==== design/icache_bypass_pkg.sv ====
// ************************************************
// Instruction fetch bypass package
// Shared types and alignment widths
// ************************************************

`include "icache_bypass_config.svh"

package icache_bypass_pkg;

  typedef logic [`ICB_FETCH_AW-1:0]   addr_t;
  typedef logic [`ICB_FETCH_DW-1:0]   fetch_word_t;
  typedef logic [`ICB_LINE_WIDTH-1:0] line_t;

  // Per-port vectors and arrays
  typedef logic [`ICB_NR_FETCH_PORTS-1:0]        port_vec_t;
  typedef addr_t [`ICB_NR_FETCH_PORTS-1:0]       port_addr_t;
  typedef fetch_word_t [`ICB_NR_FETCH_PORTS-1:0] port_word_t;

  typedef enum logic [1:0] {
    Idle,
    RequestData,
    WaitResponse,
    PresentResponse
  } port_state_e;

  // Byte offset bits of a fetch word and of a cache line
  localparam int unsigned FETCH_ALIGN = $clog2(`ICB_FETCH_DW / 8);
  localparam int unsigned LINE_ALIGN  = $clog2(`ICB_LINE_WIDTH / 8);

endpackage

// ==== design/bypass_if.sv ====
// ************************************************
// Bypass request and response bundle
// Joins port controllers, arbiter and steering
// ************************************************

`timescale 1ns/1ns

interface bypass_if;
  import icache_bypass_pkg::*;

  // Line requests with one lane per fetch port
  port_vec_t  req_valid;
  port_addr_t req_addr;
  port_vec_t  req_ready;

  // No new request may start while the grant FIFO is full
  logic       fifo_full;

  // Refill responses whose valid is one-hot towards the owning port
  port_vec_t  rsp_valid;
  line_t      rsp_data;
  logic       rsp_error;

  modport ctrl (
    output req_valid,
    output req_addr,
    input  req_ready,
    input  fifo_full,
    input  rsp_valid,
    input  rsp_data,
    input  rsp_error
  );

  modport arb (
    input  req_valid,
    input  req_addr,
    output req_ready
  );

  modport steer (
    output fifo_full,
    output rsp_valid,
    output rsp_data,
    output rsp_error
  );

endinterface

// ==== design/bypass_port_ctrl.sv ====
// ************************************************
// Fetch port controllers
// One request FSM per port, line alignment, word
// selection and the registered fetch response
// ************************************************

`timescale 1ns/1ns
`include "icache_bypass_config.svh"

module bypass_port_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  icache_bypass_pkg::port_vec_t  inst_valid_i,
  input  icache_bypass_pkg::port_addr_t inst_addr_i,
  output icache_bypass_pkg::port_vec_t  inst_ready_o,
  output icache_bypass_pkg::port_word_t inst_data_o,
  output icache_bypass_pkg::port_vec_t  inst_error_o,
  bypass_if.ctrl                        bus_o
);
  import icache_bypass_pkg::*;

  localparam int unsigned NrPorts  = `ICB_NR_FETCH_PORTS;
  localparam int unsigned WordSelW = LINE_ALIGN - FETCH_ALIGN;

  port_state_e state_d [NrPorts];
  port_state_e state_q [NrPorts];

  // Word picked out of the returning line for each port
  port_word_t  sel_word;

  for (genvar i = 0; i < NrPorts; i++) begin : gen_port
    logic [WordSelW-1:0] word_sel;
    line_t               shifted_line;

    // Requests always cover a whole line
    assign bus_o.req_addr[i] = {inst_addr_i[i][`ICB_FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};

    // The requester holds its address, so the offset is still valid at response time
    assign word_sel     = inst_addr_i[i][LINE_ALIGN-1:FETCH_ALIGN];
    assign shifted_line = bus_o.rsp_data >> (word_sel * `ICB_FETCH_DW);
    assign sel_word[i]  = shifted_line[`ICB_FETCH_DW-1:0];

    // Withdraw the request while there is no room to track its response
    assign bus_o.req_valid[i] = (state_q[i] == RequestData) && !bus_o.fifo_full;

    // The registered word is presented for a single cycle
    assign inst_ready_o[i] = (state_q[i] == PresentResponse);
  end

  always_comb begin
    for (int i = 0; i < NrPorts; i++) begin
      state_d[i] = state_q[i];
      unique case (state_q[i])
        Idle: begin
          if (inst_valid_i[i]) begin
            state_d[i] = RequestData;
          end
        end
        RequestData: begin
          if (!bus_o.fifo_full && bus_o.req_ready[i]) begin
            state_d[i] = WaitResponse;
          end
        end
        WaitResponse: begin
          if (bus_o.rsp_valid[i]) begin
            state_d[i] = PresentResponse;
          end
        end
        PresentResponse: begin
          state_d[i] = Idle;
        end
        default: begin
          state_d[i] = Idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NrPorts; i++) begin
        state_q[i] <= Idle;
      end
    end else begin
      state_q <= state_d;
    end
  end

  // Capture word and error when this port's refill comes back
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NrPorts; i++) begin
      if (bus_o.rsp_valid[i]) begin
        inst_data_o[i]  <= sel_word[i];
        inst_error_o[i] <= bus_o.rsp_error;
      end
    end
  end

endmodule

// ==== design/refill_rr_arbiter.sv ====
// ************************************************
// Refill request arbiter
// Round-robin choice among port line requests
// ************************************************

`timescale 1ns/1ns
`include "icache_bypass_config.svh"

module refill_rr_arbiter (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  bypass_if.arb                        bus_i,
  output logic                         refill_req_valid_o,
  output icache_bypass_pkg::addr_t     refill_req_addr_o,
  input  logic                         refill_req_ready_i,
  output icache_bypass_pkg::port_vec_t grant_o
);
  import icache_bypass_pkg::*;

  localparam int unsigned NrPorts = `ICB_NR_FETCH_PORTS;
  localparam int unsigned IdxW    = (NrPorts > 1) ? $clog2(NrPorts) : 1;

  logic [IdxW-1:0] ptr_q;
  logic [IdxW-1:0] ptr_d;
  logic [IdxW-1:0] rr_idx;
  logic [IdxW-1:0] sel_idx;
  logic [IdxW-1:0] lock_idx_q;
  logic            lock_q;
  logic            rr_found;
  logic            handshake;
  port_vec_t       sel_onehot;
  port_vec_t       accept_vec;

  // First requesting port at or after the pointer
  always_comb begin
    rr_idx   = ptr_q;
    rr_found = 1'b0;
    for (int k = 0; k < NrPorts; k++) begin
      if (!rr_found && bus_i.req_valid[(int'(ptr_q) + k) % NrPorts]) begin
        rr_found = 1'b1;
        rr_idx   = IdxW'((int'(ptr_q) + k) % NrPorts);
      end
    end
  end

  // A stalled request keeps its port so the address stays stable
  assign sel_idx            = lock_q ? lock_idx_q : rr_idx;
  assign refill_req_valid_o = lock_q ? bus_i.req_valid[lock_idx_q] : rr_found;
  assign refill_req_addr_o  = bus_i.req_addr[sel_idx];

  assign handshake  = refill_req_valid_o && refill_req_ready_i;
  assign sel_onehot = port_vec_t'(1'b1) << sel_idx;
  assign accept_vec = sel_onehot & {NrPorts{handshake}};

  assign bus_i.req_ready = accept_vec;
  assign grant_o         = accept_vec;

  assign ptr_d = !handshake ? ptr_q :
                 (sel_idx == IdxW'(NrPorts - 1)) ? '0 : sel_idx + 1'b1;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      ptr_q      <= ptr_d;
      lock_q     <= refill_req_valid_o && !refill_req_ready_i;
      lock_idx_q <= sel_idx;
    end
  end

endmodule

// ==== design/refill_rsp_steer.sv ====
// ************************************************
// Refill response steering
// In-order FIFO of grants routes each response
// back to the port that asked for it
// ************************************************

`timescale 1ns/1ns
`include "icache_bypass_config.svh"

module refill_rsp_steer (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  icache_bypass_pkg::port_vec_t grant_i,
  bypass_if.steer                      bus_o,
  input  logic                         refill_rsp_valid_i,
  input  icache_bypass_pkg::line_t     refill_rsp_data_i,
  input  logic                         refill_rsp_error_i,
  output logic                         refill_rsp_ready_o
);
  import icache_bypass_pkg::*;

  localparam int unsigned NrPorts = `ICB_NR_FETCH_PORTS;
  localparam int unsigned Depth   = `ICB_RSP_FIFO_DEPTH;
  localparam int unsigned PtrW    = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW    = $clog2(Depth + 1);

  port_vec_t       grant_mem [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;
  logic            empty;
  port_vec_t       head;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push  = |grant_i;
  assign empty = (count_q == '0);
  assign pop   = refill_rsp_valid_i && !empty;
  assign head  = grant_mem[rd_ptr_q];

  // Only accept responses for which a grant is recorded
  assign refill_rsp_ready_o = !empty;

  assign bus_o.fifo_full = (count_q == CntW'(Depth));
  assign bus_o.rsp_valid = head & {NrPorts{pop}};
  assign bus_o.rsp_data  = refill_rsp_data_i;
  assign bus_o.rsp_error = refill_rsp_error_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      grant_mem[wr_ptr_q] <= grant_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      unique case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== design/icache_bypass.sv ====
// ************************************************
// Multi-port uncached instruction fetch
// Shares one line refill port among all fetch
// ports and returns the addressed word
// ************************************************

`timescale 1ns/1ns

module icache_bypass (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // Fetch ports
  input  icache_bypass_pkg::port_vec_t  inst_valid_i,
  input  icache_bypass_pkg::port_addr_t inst_addr_i,
  output icache_bypass_pkg::port_vec_t  inst_ready_o,
  output icache_bypass_pkg::port_word_t inst_data_o,
  output icache_bypass_pkg::port_vec_t  inst_error_o,

  // Line refill request
  output logic                          refill_req_valid_o,
  output icache_bypass_pkg::addr_t      refill_req_addr_o,
  input  logic                          refill_req_ready_i,

  // Line refill responses come back in request order
  input  logic                          refill_rsp_valid_i,
  input  icache_bypass_pkg::line_t      refill_rsp_data_i,
  input  logic                          refill_rsp_error_i,
  output logic                          refill_rsp_ready_o
);
  import icache_bypass_pkg::*;

  // One-hot port of each accepted request
  port_vec_t grant;

  bypass_if bus ();

  bypass_port_ctrl i_port_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_addr_i  (inst_addr_i),
    .inst_ready_o (inst_ready_o),
    .inst_data_o  (inst_data_o),
    .inst_error_o (inst_error_o),
    .bus_o        (bus.ctrl)
  );

  refill_rr_arbiter i_arbiter (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .bus_i              (bus.arb),
    .refill_req_valid_o (refill_req_valid_o),
    .refill_req_addr_o  (refill_req_addr_o),
    .refill_req_ready_i (refill_req_ready_i),
    .grant_o            (grant)
  );

  refill_rsp_steer i_rsp_steer (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .grant_i            (grant),
    .bus_o              (bus.steer),
    .refill_rsp_valid_i (refill_rsp_valid_i),
    .refill_rsp_data_i  (refill_rsp_data_i),
    .refill_rsp_error_i (refill_rsp_error_i),
    .refill_rsp_ready_o (refill_rsp_ready_o)
  );

endmodule

// ==== verif/tb_clk_gen.sv ====
// ************************************************
// Testbench clock and reset generator
// ************************************************

`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 8,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset is released just after an edge like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== verif/icache_bypass_props.sv ====
// ************************************************
// Protocol properties of the fetch bypass ports
// Alignment, request stability, reset values and
// one-cycle presentation
// ************************************************

`timescale 1ns/1ns

module icache_bypass_props (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input icache_bypass_pkg::port_vec_t inst_ready_o,
  input logic                         refill_req_valid_o,
  input icache_bypass_pkg::addr_t     refill_req_addr_o,
  input logic                         refill_req_ready_i,
  input logic                         refill_rsp_valid_i,
  input logic                         refill_rsp_ready_o
);
  import icache_bypass_pkg::*;

  // Failure count of each property
  int unsigned align_fails  = 0;
  int unsigned stable_fails = 0;
  int unsigned reset_fails  = 0;
  int unsigned pulse_fails  = 0;
  int unsigned accept_fails = 0;
  int unsigned fail_cnt;

  assign fail_cnt = align_fails + stable_fails + reset_fails + pulse_fails + accept_fails;

  assert_line_aligned: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    refill_req_addr_o[LINE_ALIGN-1:0] == '0
  ) else begin
    $error("refill request address is not line aligned");
    align_fails++;
  end

  // A stalled line request keeps its valid and its address
  assert_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    refill_req_valid_o && !refill_req_ready_i |=> refill_req_valid_o && $stable(refill_req_addr_o)
  ) else begin
    $error("stalled refill request changed before it was accepted");
    stable_fails++;
  end

  assert_reset_idle: assert property (
    @(posedge clk_i)
    !rst_n_i |=> inst_ready_o == '0 && !refill_req_valid_o && !refill_rsp_ready_o
  ) else begin
    $error("outputs not idle right after a reset edge");
    reset_fails++;
  end

  assert_ready_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (inst_ready_o & $past(inst_ready_o)) == '0
  ) else begin
    $error("inst_ready_o held high for more than one cycle");
    pulse_fails++;
  end

  // A response that is not accepted must never reach a fetch port
  assert_no_blind_accept: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    refill_rsp_valid_i && !refill_rsp_ready_o |=> inst_ready_o == '0
  ) else begin
    $error("refill response reached a port while refill_rsp_ready_o was low");
    accept_fails++;
  end

endmodule

bind icache_bypass icache_bypass_props props0 (
  .clk_i              (clk_i),
  .rst_n_i            (rst_n_i),
  .inst_ready_o       (inst_ready_o),
  .refill_req_valid_o (refill_req_valid_o),
  .refill_req_addr_o  (refill_req_addr_o),
  .refill_req_ready_i (refill_req_ready_i),
  .refill_rsp_valid_i (refill_rsp_valid_i),
  .refill_rsp_ready_o (refill_rsp_ready_o)
);

// ==== verif/tb_icache_bypass.sv ====
// ************************************************
// Testbench of the multi-port instruction fetch
// Drives both fetch ports, models the line refill
// memory and checks every presented word
// ************************************************

`timescale 1ns/1ns
`include "icache_bypass_config.svh"

module tb_icache_bypass;
  import icache_bypass_pkg::*;

  localparam int NrPorts     = `ICB_NR_FETCH_PORTS;
  localparam int NrOffsets   = 1 << (LINE_ALIGN - FETCH_ALIGN);
  localparam int MaxFetches  = 200;
  localparam int FetchCycles = 20;
  localparam int MaxCycles   = MaxFetches * FetchCycles;

  logic       clk;
  logic       rst_n;
  port_vec_t  inst_valid;
  port_addr_t inst_addr;
  port_vec_t  inst_ready;
  port_word_t inst_data;
  port_vec_t  inst_error;
  logic       refill_req_valid;
  addr_t      refill_req_addr;
  logic       refill_req_ready;
  logic       refill_rsp_valid;
  line_t      refill_rsp_data;
  logic       refill_rsp_error;
  logic       refill_rsp_ready;

  integer      seed;
  int          cycle_cnt;
  int          test_cnt;
  int unsigned check_errs;
  int unsigned seq_errs;
  int unsigned checked;
  int unsigned queued;

  // Refill memory model and its stall controls
  addr_t pend_q [$];
  int    rsp_wait;
  logic  stall_mode;
  logic  hold_req_low;
  logic  spurious_rsp;
  logic  gap_mode;

  // Fetches still to issue and ports waiting for their word
  addr_t     fetch_q [NrPorts][$];
  port_vec_t busy;

  tb_clk_gen #(.PeriodNs(8), .ResetCycles(3)) clk_gen0 (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  icache_bypass dut0 (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .inst_valid_i       (inst_valid),
    .inst_addr_i        (inst_addr),
    .inst_ready_o       (inst_ready),
    .inst_data_o        (inst_data),
    .inst_error_o       (inst_error),
    .refill_req_valid_o (refill_req_valid),
    .refill_req_addr_o  (refill_req_addr),
    .refill_req_ready_i (refill_req_ready),
    .refill_rsp_valid_i (refill_rsp_valid),
    .refill_rsp_data_i  (refill_rsp_data),
    .refill_rsp_error_i (refill_rsp_error),
    .refill_rsp_ready_o (refill_rsp_ready)
  );

  // Word k of the line at A holds (A + 4k) ^ 32'h5a5a0000
  function automatic fetch_word_t expect_word(addr_t addr);
    addr_t line_base;
    addr_t k;
    line_base = addr & ~addr_t'((1 << LINE_ALIGN) - 1);
    k         = addr_t'(addr[LINE_ALIGN-1:FETCH_ALIGN]);
    return fetch_word_t'((line_base + addr_t'(4) * k) ^ 32'h5a5a0000);
  endfunction

  function automatic line_t model_line(addr_t base);
    line_t line;
    for (int k = 0; k < NrOffsets; k++) begin
      line[k*`ICB_FETCH_DW +: `ICB_FETCH_DW] = (base + addr_t'(4 * k)) ^ 32'h5a5a0000;
    end
    return line;
  endfunction

  function automatic int unsigned total_errors();
    return check_errs + seq_errs + dut0.props0.fail_cnt;
  endfunction

  function automatic logic work_left();
    logic left;
    left = (busy != '0) || (pend_q.size() > 0);
    for (int p = 0; p < NrPorts; p++) begin
      left = left || (fetch_q[p].size() > 0);
    end
    return left;
  endfunction

  // Every presented word is checked against the memory rule
  always @(posedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < NrPorts; p++) begin
        if (inst_ready[p]) begin
          checked++;
          assert (inst_valid[p]) else begin
            $display("port %0d presented a word with no fetch pending at %0t", p, $time);
            check_errs++;
          end
          assert (inst_data[p] == expect_word(inst_addr[p])) else begin
            $display("ERROR time %0t: inst_data_o[%0d] expected %h actual %h",
                     $time, p, expect_word(inst_addr[p]), inst_data[p]);
            check_errs++;
          end
          assert (inst_error[p] == inst_addr[p][31]) else begin
            $display("ERROR time %0t: inst_error_o[%0d] expected %b actual %b",
                     $time, p, inst_addr[p][31], inst_error[p]);
            check_errs++;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MaxCycles) begin
      $display("timeout: fetches still open after %0d cycles", MaxCycles);
      $display("sim failed");
      $finish;
    end
  end

  // One clock of the environment samples at the edge and drives 1 ns later
  task automatic step();
    @(posedge clk);
    if (refill_rsp_valid && refill_rsp_ready && pend_q.size() > 0) begin
      void'(pend_q.pop_front());
      rsp_wait = -1;
    end
    if (refill_req_valid && refill_req_ready) begin
      pend_q.push_back(refill_req_addr);
    end
    for (int p = 0; p < NrPorts; p++) begin
      if (busy[p] && inst_ready[p]) begin
        busy[p] = 1'b0;
      end
    end
    #1;
    if (hold_req_low) begin
      refill_req_ready = 1'b0;
    end else if (stall_mode) begin
      refill_req_ready = (($random(seed) & 3) != 0);
    end else begin
      refill_req_ready = 1'b1;
    end
    if (pend_q.size() > 0) begin
      if (rsp_wait < 0) begin
        rsp_wait = $random(seed) & 3;
      end
      if (rsp_wait == 0) begin
        refill_rsp_valid = 1'b1;
        refill_rsp_data  = model_line(pend_q[0]);
        refill_rsp_error = pend_q[0][31];
      end else begin
        refill_rsp_valid = 1'b0;
        rsp_wait--;
      end
    end else begin
      refill_rsp_valid = spurious_rsp;
      refill_rsp_data  = model_line($random(seed));
      refill_rsp_error = spurious_rsp;
    end
    for (int p = 0; p < NrPorts; p++) begin
      if (!busy[p] && fetch_q[p].size() > 0) begin
        if (!gap_mode || (($random(seed) & 1) == 1)) begin
          inst_addr[p] = fetch_q[p].pop_front();
          busy[p]      = 1'b1;
        end
      end
      inst_valid[p] = busy[p];
    end
  endtask

  task automatic compare_value(string sig, logic [31:0] exp_val, logic [31:0] act_val);
    assert (act_val == exp_val) else begin
      $display("ERROR time %0t: %s expected %0h actual %0h", $time, sig, exp_val, act_val);
      seq_errs++;
    end
  endtask

  task automatic queue_fetch(int p, addr_t addr);
    fetch_q[p].push_back(addr);
    queued++;
  endtask

  function automatic addr_t random_addr();
    addr_t a;
    a = $random(seed);
    a[FETCH_ALIGN-1:0] = '0;
    return a;
  endfunction

  task automatic run_until_done();
    while (work_left()) begin
      step();
    end
  endtask

  task automatic report_test(string name, int unsigned c0, int unsigned e0);
    test_cnt++;
    $display("%0t test %s done: %0d fetches checked, %0d errors",
             $time, name, checked - c0, total_errors() - e0);
  endtask

  task automatic reset_state();
    int unsigned c0;
    int unsigned e0;
    c0 = checked;
    e0 = total_errors();
    repeat (2) step();
    compare_value("inst_ready_o", 32'(0), 32'(inst_ready));
    compare_value("refill_req_valid_o", 32'(0), 32'(refill_req_valid));
    compare_value("refill_rsp_ready_o", 32'(0), 32'(refill_rsp_ready));
    report_test("reset_state", c0, e0);
  endtask

  // Responses with nothing outstanding must be refused
  task automatic spurious_response();
    int unsigned c0;
    int unsigned e0;
    c0 = checked;
    e0 = total_errors();
    spurious_rsp = 1'b1;
    repeat (10) begin
      step();
      compare_value("refill_rsp_ready_o", 32'(0), 32'(refill_rsp_ready));
      compare_value("inst_ready_o", 32'(0), 32'(inst_ready));
    end
    spurious_rsp = 1'b0;
    step();
    report_test("spurious_response", c0, e0);
  endtask

  task automatic word_select();
    int unsigned c0;
    int unsigned e0;
    addr_t       a;
    c0 = checked;
    e0 = total_errors();
    for (int p = 0; p < NrPorts; p++) begin
      for (int hi = 0; hi < 2; hi++) begin
        for (int off = 0; off < NrOffsets; off++) begin
          a = random_addr();
          a[31] = hi[0];
          a[LINE_ALIGN-1:FETCH_ALIGN] = off[LINE_ALIGN-FETCH_ALIGN-1:0];
          queue_fetch(p, a);
        end
      end
    end
    run_until_done();
    report_test("word_select", c0, e0);
  endtask

  task automatic concurrent_fetches();
    int unsigned c0;
    int unsigned e0;
    c0 = checked;
    e0 = total_errors();
    stall_mode = 1'b1;
    gap_mode   = 1'b1;
    for (int n = 0; n < 80; n++) begin
      for (int p = 0; p < NrPorts; p++) begin
        queue_fetch(p, random_addr());
      end
    end
    run_until_done();
    stall_mode = 1'b0;
    gap_mode   = 1'b0;
    report_test("concurrent_fetches", c0, e0);
  endtask

  task automatic request_backpressure();
    int unsigned c0;
    int unsigned e0;
    c0 = checked;
    e0 = total_errors();
    hold_req_low = 1'b1;
    for (int p = 0; p < NrPorts; p++) begin
      queue_fetch(p, random_addr());
    end
    repeat (30) begin
      step();
      compare_value("inst_ready_o", 32'(0), 32'(inst_ready));
    end
    hold_req_low = 1'b0;
    run_until_done();
    report_test("request_backpressure", c0, e0);
  endtask

  initial begin
    seed             = 32'hc7610a33;
    cycle_cnt        = 0;
    test_cnt         = 0;
    check_errs       = 0;
    seq_errs         = 0;
    checked          = 0;
    queued           = 0;
    rsp_wait         = -1;
    stall_mode       = 1'b0;
    hold_req_low     = 1'b0;
    spurious_rsp     = 1'b0;
    gap_mode         = 1'b0;
    busy             = '0;
    inst_valid       = '0;
    inst_addr        = '0;
    refill_req_ready = 1'b0;
    refill_rsp_valid = 1'b0;
    refill_rsp_data  = '0;
    refill_rsp_error = 1'b0;
    @(posedge rst_n);
    reset_state();
    spurious_response();
    word_select();
    concurrent_fetches();
    request_backpressure();
    if (checked != queued) begin
      $display("only %0d of %0d fetches were presented", checked, queued);
      seq_errs++;
    end
    $display("tests %0d, fetches checked %0d, errors %0d", test_cnt, checked, total_errors());
    if (total_errors() == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== icache_bypass.f ====
+incdir+design
design/icache_bypass_pkg.sv
design/bypass_if.sv
design/bypass_port_ctrl.sv
design/refill_rr_arbiter.sv
design/refill_rsp_steer.sv
design/icache_bypass.sv
verif/tb_clk_gen.sv
verif/icache_bypass_props.sv
verif/tb_icache_bypass.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the icache_bypass testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f icache_bypass.f \
  --top-module tb_icache_bypass \
  -o sim_icache_bypass

./obj_dir/sim_icache_bypass +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
